/* vga_timing_pkg.sv */
package vga_timing_pkg;

	// screen coordinate wide enough for the full 800x525 raster
	typedef logic [9:0] coord_t;

	// horizontal timing in pixels
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT  = 16;
	localparam int H_SYNC   = 96;
	localparam int H_BACK   = 48;

	// vertical timing in lines
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT  = 10;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 33;

endpackage

/* battle_scene_pkg.sv */
package battle_scene_pkg;

	typedef logic [3:0]  color_t;
	typedef logic [3:0]  pixel_index_t;
	typedef logic [15:0] bkg_addr_t;
	typedef logic [10:0] sprite_addr_t;
	typedef logic [7:0]  health_t;
	typedef logic [3:0]  battle_state_t;

	// battle viewport on the 640x480 screen
	localparam int VIEW_X0 = 200;
	localparam int VIEW_Y0 = 160;
	localparam int VIEW_W  = 240;
	localparam int VIEW_H  = 160;

	// opponent sprite
	localparam int SPRITE_X0 = 360;
	localparam int SPRITE_Y0 = 183;
	localparam int SPRITE_W  = 42;
	localparam int SPRITE_H  = 40;

	// menu cursor corners
	localparam int CURSOR_SIZE = 10;
	localparam int CURSOR_COL0 = 292;
	localparam int CURSOR_COL1 = 352;
	localparam int CURSOR_ROW0 = 281;
	localparam int CURSOR_ROW1 = 303;

	// health bars grow left from an exclusive right end
	localparam int OPP_BAR_RIGHT  = 267;
	localparam int OPP_BAR_FULL   = 36;
	localparam int OPP_BAR_TOP    = 189;
	localparam int OPP_BAR_BOT    = 190;
	localparam int USER_BAR_RIGHT = 435;
	localparam int USER_BAR_FULL  = 38;
	localparam int USER_BAR_TOP   = 244;
	localparam int USER_BAR_BOT   = 247;
	localparam int HEALTH_FULL    = 100;

	// background palette
	function automatic color_t bkg_green(pixel_index_t idx);
		return color_t'(4'd15 - idx);
	endfunction

	function automatic color_t bkg_blue(pixel_index_t idx);
		return color_t'(idx ^ 4'd5);
	endfunction

endpackage

/* vga_raster_counter.sv */
`timescale 1ns/1ps

module vga_raster_counter #(
	parameter int H_ACTIVE = vga_timing_pkg::H_ACTIVE,
	parameter int H_FRONT  = vga_timing_pkg::H_FRONT,
	parameter int H_SYNC   = vga_timing_pkg::H_SYNC,
	parameter int H_BACK   = vga_timing_pkg::H_BACK,
	parameter int V_ACTIVE = vga_timing_pkg::V_ACTIVE,
	parameter int V_FRONT  = vga_timing_pkg::V_FRONT,
	parameter int V_SYNC   = vga_timing_pkg::V_SYNC,
	parameter int V_BACK   = vga_timing_pkg::V_BACK
) (
	input  logic                   vga_clk,
	input  logic                   rst_n,
	output vga_timing_pkg::coord_t draw_x,
	output vga_timing_pkg::coord_t draw_y,
	output logic                   hsync,
	output logic                   vsync,
	output logic                   active,
	output logic                   frame_start
);
	import vga_timing_pkg::*;

	localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
	localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

	coord_t h_next;
	coord_t v_next;

	always_comb begin
		h_next = draw_x + coord_t'(1);
		v_next = draw_y;
		if (draw_x == coord_t'(H_TOTAL - 1)) begin
			h_next = '0;
			if (draw_y == coord_t'(V_TOTAL - 1))
				v_next = '0;
			else
				v_next = draw_y + coord_t'(1);
		end
	end

	// flags decoded from the next position so they line up with the counters
	always_ff @(posedge vga_clk or negedge rst_n) begin
		if (!rst_n) begin
			draw_x      <= '0;
			draw_y      <= '0;
			hsync       <= 1'b1;
			vsync       <= 1'b1;
			active      <= 1'b0;
			frame_start <= 1'b0;
		end else begin
			draw_x      <= h_next;
			draw_y      <= v_next;
			hsync       <= !(h_next >= H_SYNC_START && h_next < H_SYNC_START + H_SYNC);
			vsync       <= !(v_next >= V_SYNC_START && v_next < V_SYNC_START + V_SYNC);
			active      <= (h_next < H_ACTIVE) && (v_next < V_ACTIVE);
			// first pixel of the front porch line
			frame_start <= (h_next == '0) && (v_next == coord_t'(V_ACTIVE));
		end
	end

endmodule

/* health_latch_fsm.sv */
`timescale 1ns/1ps

module health_latch_fsm (
	input  logic                      vga_clk,
	input  logic                      rst_n,
	input  logic                      frame_start,
	input  logic                      health_req,
	input  battle_scene_pkg::health_t health_opp_in,
	input  battle_scene_pkg::health_t health_user_in,
	output logic                      health_ack,
	output battle_scene_pkg::health_t health_opp,
	output battle_scene_pkg::health_t health_user
);
	typedef enum logic [1:0] {
		idle,
		wait_frame,
		acked
	} state_t;

	state_t state;
	state_t state_next;

	always_comb begin
		state_next = state;
		case (state)
			idle: begin
				if (health_req)
					state_next = wait_frame;
			end
			// hold off until vertical blank so bars never tear
			wait_frame: begin
				if (frame_start)
					state_next = acked;
			end
			acked: begin
				if (!health_req)
					state_next = idle;
			end
			default: state_next = idle;
		endcase
	end

	always_ff @(posedge vga_clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= idle;
			health_opp  <= '0;
			health_user <= '0;
		end else begin
			state <= state_next;
			if (state == wait_frame && frame_start) begin
				health_opp  <= health_opp_in;
				health_user <= health_user_in;
			end
		end
	end

	assign health_ack = (state == acked);

endmodule

/* viewport_mapper.sv */
`timescale 1ns/1ps

module viewport_mapper (
	input  logic                           vga_clk,
	input  logic                           rst_n,
	input  vga_timing_pkg::coord_t         draw_x,
	input  vga_timing_pkg::coord_t         draw_y,
	output logic                           in_view,
	output logic                           sprite_on,
	output battle_scene_pkg::bkg_addr_t    bkg_addr,
	output battle_scene_pkg::sprite_addr_t sprite_addr
);
	import vga_timing_pkg::*;
	import battle_scene_pkg::*;

	coord_t view_x;
	coord_t view_y;
	coord_t spr_x;
	coord_t spr_y;
	logic   view_hit;
	logic   spr_hit;

	// window-relative position wraps when left of or above the window
	assign view_x = draw_x - coord_t'(VIEW_X0);
	assign view_y = draw_y - coord_t'(VIEW_Y0);
	assign spr_x  = draw_x - coord_t'(SPRITE_X0);
	assign spr_y  = draw_y - coord_t'(SPRITE_Y0);

	assign view_hit = (draw_x >= VIEW_X0) && (view_x < VIEW_W)
		&& (draw_y >= VIEW_Y0) && (view_y < VIEW_H);
	assign spr_hit = (draw_x >= SPRITE_X0) && (spr_x < SPRITE_W)
		&& (draw_y >= SPRITE_Y0) && (spr_y < SPRITE_H);

	always_ff @(posedge vga_clk or negedge rst_n) begin
		if (!rst_n) begin
			in_view     <= 1'b0;
			sprite_on   <= 1'b0;
			bkg_addr    <= '0;
			sprite_addr <= '0;
		end else begin
			in_view   <= view_hit;
			sprite_on <= spr_hit;
			if (view_hit)
				bkg_addr <= bkg_addr_t'(view_x) + bkg_addr_t'(view_y) * bkg_addr_t'(VIEW_W);
			else
				bkg_addr <= '0;
			if (spr_hit)
				sprite_addr <= sprite_addr_t'(spr_x)
					+ sprite_addr_t'(spr_y) * sprite_addr_t'(SPRITE_W);
			else
				sprite_addr <= '0;
		end
	end

endmodule

/* hud_overlay.sv */
`timescale 1ns/1ps

module hud_overlay (
	input  logic                            vga_clk,
	input  logic                            rst_n,
	input  vga_timing_pkg::coord_t          draw_x,
	input  vga_timing_pkg::coord_t          draw_y,
	input  battle_scene_pkg::battle_state_t battle_state,
	input  battle_scene_pkg::health_t       health_opp,
	input  battle_scene_pkg::health_t       health_user,
	output logic                            cursor_on,
	output logic                            bar_on
);
	import vga_timing_pkg::*;
	import battle_scene_pkg::*;

	coord_t cursor_x;
	coord_t cursor_y;
	logic   cursor_valid;
	logic   cursor_hit;
	coord_t opp_width;
	coord_t user_width;
	logic   opp_hit;
	logic   user_hit;

	// one bar pixel per three health points up to the full width
	function automatic coord_t bar_width(health_t health, int full);
		if (health >= HEALTH_FULL)
			return coord_t'(full);
		return coord_t'(health / 8'd3);
	endfunction

	always_comb begin
		cursor_valid = 1'b1;
		cursor_x     = coord_t'(CURSOR_COL0);
		cursor_y     = coord_t'(CURSOR_ROW0);
		case (battle_state)
			4'd1, 4'd5: ;
			4'd2, 4'd6: cursor_x = coord_t'(CURSOR_COL1);
			4'd3, 4'd7: cursor_y = coord_t'(CURSOR_ROW1);
			4'd4, 4'd8: begin
				cursor_x = coord_t'(CURSOR_COL1);
				cursor_y = coord_t'(CURSOR_ROW1);
			end
			default: cursor_valid = 1'b0;
		endcase
	end

	assign cursor_hit = cursor_valid
		&& (draw_x >= cursor_x) && (draw_x < cursor_x + coord_t'(CURSOR_SIZE))
		&& (draw_y >= cursor_y) && (draw_y < cursor_y + coord_t'(CURSOR_SIZE));

	assign opp_width  = bar_width(health_opp, OPP_BAR_FULL);
	assign user_width = bar_width(health_user, USER_BAR_FULL);

	assign opp_hit = (draw_x >= coord_t'(OPP_BAR_RIGHT) - opp_width)
		&& (draw_x < OPP_BAR_RIGHT) && (draw_y >= OPP_BAR_TOP) && (draw_y <= OPP_BAR_BOT);
	assign user_hit = (draw_x >= coord_t'(USER_BAR_RIGHT) - user_width)
		&& (draw_x < USER_BAR_RIGHT) && (draw_y >= USER_BAR_TOP) && (draw_y <= USER_BAR_BOT);

	always_ff @(posedge vga_clk or negedge rst_n) begin
		if (!rst_n) begin
			cursor_on <= 1'b0;
			bar_on    <= 1'b0;
		end else begin
			cursor_on <= cursor_hit;
			bar_on    <= opp_hit || user_hit;
		end
	end

endmodule

/* pixel_compositor.sv */
`timescale 1ns/1ps

module pixel_compositor (
	input  logic                           vga_clk,
	input  logic                           rst_n,
	input  logic                           in_view,
	input  logic                           sprite_on,
	input  logic                           cursor_on,
	input  logic                           bar_on,
	input  logic                           hsync,
	input  logic                           vsync,
	input  logic                           active,
	input  battle_scene_pkg::pixel_index_t bkg_index,
	input  battle_scene_pkg::pixel_index_t sprite_index,
	output battle_scene_pkg::color_t       red,
	output battle_scene_pkg::color_t       green,
	output battle_scene_pkg::color_t       blue,
	output logic                           hsync_out,
	output logic                           vsync_out,
	output logic                           de
);
	import battle_scene_pkg::*;

	// raster signals arrive one stage ahead of the mapper flags
	logic [2:0] hs_pipe;
	logic [2:0] vs_pipe;
	logic [2:0] act_pipe;
	logic       in_view_q;
	logic       sprite_q;
	logic       cursor_q;
	logic       bar_q;

	always_ff @(posedge vga_clk or negedge rst_n) begin
		if (!rst_n) begin
			hs_pipe   <= '1;
			vs_pipe   <= '1;
			act_pipe  <= '0;
			in_view_q <= 1'b0;
			sprite_q  <= 1'b0;
			cursor_q  <= 1'b0;
			bar_q     <= 1'b0;
		end else begin
			hs_pipe   <= {hs_pipe[1:0], hsync};
			vs_pipe   <= {vs_pipe[1:0], vsync};
			act_pipe  <= {act_pipe[1:0], active};
			in_view_q <= in_view;
			sprite_q  <= sprite_on;
			cursor_q  <= cursor_on;
			bar_q     <= bar_on;
		end
	end

	// later assignments win so the lowest priority comes first
	always_ff @(posedge vga_clk or negedge rst_n) begin
		if (!rst_n) begin
			red   <= '0;
			green <= '0;
			blue  <= '0;
		end else begin
			red   <= '0;
			green <= '0;
			blue  <= '0;
			if (act_pipe[1] && in_view_q) begin
				red   <= bkg_index;
				green <= bkg_green(bkg_index);
				blue  <= bkg_blue(bkg_index);
				if (cursor_q) begin
					red   <= '0;
					green <= '0;
					blue  <= '0;
				end
				// index 0 is see-through
				if (sprite_q && sprite_index != '0) begin
					red   <= sprite_index;
					green <= sprite_index;
					blue  <= '0;
				end
				if (bar_q) begin
					red   <= 4'hf;
					green <= '0;
					blue  <= '0;
				end
			end
		end
	end

	assign hsync_out = hs_pipe[2];
	assign vsync_out = vs_pipe[2];
	assign de        = act_pipe[2];

endmodule

/* battle_display_top.sv */
`timescale 1ns/1ps

module battle_display_top #(
	parameter int H_ACTIVE = vga_timing_pkg::H_ACTIVE,
	parameter int H_FRONT  = vga_timing_pkg::H_FRONT,
	parameter int H_SYNC   = vga_timing_pkg::H_SYNC,
	parameter int H_BACK   = vga_timing_pkg::H_BACK,
	parameter int V_ACTIVE = vga_timing_pkg::V_ACTIVE,
	parameter int V_FRONT  = vga_timing_pkg::V_FRONT,
	parameter int V_SYNC   = vga_timing_pkg::V_SYNC,
	parameter int V_BACK   = vga_timing_pkg::V_BACK
) (
	input  logic                            vga_clk,
	input  logic                            rst_n,
	input  logic                            health_req,
	input  battle_scene_pkg::health_t       health_opp_in,
	input  battle_scene_pkg::health_t       health_user_in,
	input  battle_scene_pkg::battle_state_t battle_state,
	input  battle_scene_pkg::pixel_index_t  bkg_index,
	input  battle_scene_pkg::pixel_index_t  sprite_index,
	output logic                            health_ack,
	output battle_scene_pkg::bkg_addr_t     bkg_addr,
	output battle_scene_pkg::sprite_addr_t  sprite_addr,
	output battle_scene_pkg::color_t        red,
	output battle_scene_pkg::color_t        green,
	output battle_scene_pkg::color_t        blue,
	output logic                            hsync_out,
	output logic                            vsync_out,
	output logic                            de
);
	import vga_timing_pkg::*;
	import battle_scene_pkg::*;

	coord_t  draw_x;
	coord_t  draw_y;
	logic    hsync;
	logic    vsync;
	logic    active;
	logic    frame_start;
	health_t health_opp;
	health_t health_user;
	logic    in_view;
	logic    sprite_on;
	logic    cursor_on;
	logic    bar_on;

	vga_raster_counter #(
		.H_ACTIVE (H_ACTIVE),
		.H_FRONT  (H_FRONT),
		.H_SYNC   (H_SYNC),
		.H_BACK   (H_BACK),
		.V_ACTIVE (V_ACTIVE),
		.V_FRONT  (V_FRONT),
		.V_SYNC   (V_SYNC),
		.V_BACK   (V_BACK)
	) i_vga_raster_counter (
		.vga_clk     (vga_clk),
		.rst_n       (rst_n),
		.draw_x      (draw_x),
		.draw_y      (draw_y),
		.hsync       (hsync),
		.vsync       (vsync),
		.active      (active),
		.frame_start (frame_start)
	);

	health_latch_fsm i_health_latch_fsm (
		.vga_clk        (vga_clk),
		.rst_n          (rst_n),
		.frame_start    (frame_start),
		.health_req     (health_req),
		.health_opp_in  (health_opp_in),
		.health_user_in (health_user_in),
		.health_ack     (health_ack),
		.health_opp     (health_opp),
		.health_user    (health_user)
	);

	viewport_mapper i_viewport_mapper (
		.vga_clk     (vga_clk),
		.rst_n       (rst_n),
		.draw_x      (draw_x),
		.draw_y      (draw_y),
		.in_view     (in_view),
		.sprite_on   (sprite_on),
		.bkg_addr    (bkg_addr),
		.sprite_addr (sprite_addr)
	);

	hud_overlay i_hud_overlay (
		.vga_clk      (vga_clk),
		.rst_n        (rst_n),
		.draw_x       (draw_x),
		.draw_y       (draw_y),
		.battle_state (battle_state),
		.health_opp   (health_opp),
		.health_user  (health_user),
		.cursor_on    (cursor_on),
		.bar_on       (bar_on)
	);

	pixel_compositor i_pixel_compositor (
		.vga_clk      (vga_clk),
		.rst_n        (rst_n),
		.in_view      (in_view),
		.sprite_on    (sprite_on),
		.cursor_on    (cursor_on),
		.bar_on       (bar_on),
		.hsync        (hsync),
		.vsync        (vsync),
		.active       (active),
		.bkg_index    (bkg_index),
		.sprite_index (sprite_index),
		.red          (red),
		.green        (green),
		.blue         (blue),
		.hsync_out    (hsync_out),
		.vsync_out    (vsync_out),
		.de           (de)
	);

endmodule

/* tb_battle_display.sv */
`timescale 1ns/1ps

module tb_battle_display;
	import vga_timing_pkg::*;
	import battle_scene_pkg::*;

	localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int FRAME_CYCLES = 800 * 525;
	localparam int NUM_ROWS     = 6;
	localparam int MAX_SHOWN    = 10;

	logic          vga_clk;
	logic          rst_n;
	logic          health_req;
	health_t       health_opp_in;
	health_t       health_user_in;
	battle_state_t battle_state;
	pixel_index_t  bkg_index;
	pixel_index_t  sprite_index;
	logic          health_ack;
	bkg_addr_t     bkg_addr;
	sprite_addr_t  sprite_addr;
	color_t        red;
	color_t        green;
	color_t        blue;
	logic          hsync_out;
	logic          vsync_out;
	logic          de;

	// cursor column 0 marks a row without a cursor
	battle_state_t row_state [NUM_ROWS];
	health_t       row_opp [NUM_ROWS];
	health_t       row_user [NUM_ROWS];
	int            row_cur_x [NUM_ROWS];
	int            row_cur_y [NUM_ROWS];
	int            row_opp_w [NUM_ROWS];
	int            row_user_w [NUM_ROWS];

	int   errors;
	int   test_errors;
	int   tests_run;
	int   tests_failed;
	logic timed_out;

	battle_display_top i_battle_display_top (
		.vga_clk        (vga_clk),
		.rst_n          (rst_n),
		.health_req     (health_req),
		.health_opp_in  (health_opp_in),
		.health_user_in (health_user_in),
		.battle_state   (battle_state),
		.bkg_index      (bkg_index),
		.sprite_index   (sprite_index),
		.health_ack     (health_ack),
		.bkg_addr       (bkg_addr),
		.sprite_addr    (sprite_addr),
		.red            (red),
		.green          (green),
		.blue           (blue),
		.hsync_out      (hsync_out),
		.vsync_out      (vsync_out),
		.de             (de)
	);

	initial begin
		vga_clk = 1'b0;
		forever #10 vga_clk = ~vga_clk;
	end

	// synchronous ROMs with one cycle of latency
	always @(posedge vga_clk) begin
		bkg_index    <= pixel_index_t'(bkg_addr % 16);
		sprite_index <= pixel_index_t'(sprite_addr % 7);
	end

	task automatic set_row(int r, battle_state_t state, health_t opp, health_t user,
			int cur_x, int cur_y, int opp_w, int user_w);
		row_state[r]  = state;
		row_opp[r]    = opp;
		row_user[r]   = user;
		row_cur_x[r]  = cur_x;
		row_cur_y[r]  = cur_y;
		row_opp_w[r]  = opp_w;
		row_user_w[r] = user_w;
	endtask

	// reference color of one screen pixel for a table row
	function automatic logic [11:0] expected_rgb(int x, int y, int row);
		int          idx;
		int          inv;
		int          xr;
		int          sidx;
		logic [11:0] rgb;
		if (x < VIEW_X0 || x >= VIEW_X0 + VIEW_W || y < VIEW_Y0 || y >= VIEW_Y0 + VIEW_H)
			return 12'h000;
		idx = ((x - VIEW_X0) + (y - VIEW_Y0) * VIEW_W) % 16;
		inv = 15 - idx;
		xr  = idx ^ 5;
		rgb = {idx[3:0], inv[3:0], xr[3:0]};
		if (row_cur_x[row] != 0 && x >= row_cur_x[row] && x < row_cur_x[row] + CURSOR_SIZE
				&& y >= row_cur_y[row] && y < row_cur_y[row] + CURSOR_SIZE)
			rgb = 12'h000;
		if (x >= SPRITE_X0 && x < SPRITE_X0 + SPRITE_W
				&& y >= SPRITE_Y0 && y < SPRITE_Y0 + SPRITE_H) begin
			sidx = ((x - SPRITE_X0) + (y - SPRITE_Y0) * SPRITE_W) % 7;
			if (sidx != 0)
				rgb = {sidx[3:0], sidx[3:0], 4'h0};
		end
		if ((y == 189 || y == 190) && x >= 267 - row_opp_w[row] && x < 267)
			rgb = 12'hf00;
		if (y >= 244 && y <= 247 && x >= 435 - row_user_w[row] && x < 435)
			rgb = 12'hf00;
		return rgb;
	endfunction

	// four-phase handshake followed by input changes while ack is low
	task automatic load_health(health_t opp, health_t user);
		int n;
		if (health_ack) begin
			$display("error at %0t: health_ack high before health_req", $time);
			test_errors++;
		end
		health_opp_in  = opp;
		health_user_in = user;
		health_req     = 1'b1;
		n = 0;
		while (!health_ack && n < FRAME_CYCLES + 16) begin
			@(negedge vga_clk);
			n++;
		end
		if (!health_ack) begin
			$display("timeout: no health_ack within one frame of health_req");
			timed_out = 1'b1;
		end else begin
			health_req = 1'b0;
			n = 0;
			while (health_ack && n < 16) begin
				@(negedge vga_clk);
				n++;
			end
			if (health_ack) begin
				$display("timeout: health_ack stayed high after health_req dropped");
				timed_out = 1'b1;
			end
			// these would give other bar widths if they leaked through
			health_opp_in  = (opp >= HEALTH_FULL) ? 8'd30 : 8'd150;
			health_user_in = (user >= HEALTH_FULL) ? 8'd30 : 8'd150;
		end
	endtask

	task automatic wait_vsync_fall();
		int   n;
		logic prev;
		logic found;
		n     = 0;
		found = 1'b0;
		prev  = vsync_out;
		while (!found && n < FRAME_CYCLES + 100) begin
			@(negedge vga_clk);
			n++;
			found = prev && !vsync_out;
			prev  = vsync_out;
		end
		if (!found) begin
			$display("timeout: vsync_out never fell within one frame");
			timed_out = 1'b1;
		end
	endtask

	// position comes from counting de cycles and lines after vsync
	task automatic scan_frame(int row);
		int          x;
		int          y;
		int          n;
		int          hpos;
		logic        prev_de;
		logic        want_hs;
		logic        want_vs;
		logic [11:0] want;
		x       = 0;
		y       = 0;
		n       = 0;
		hpos    = -1;
		prev_de = 1'b0;
		while (y < V_ACTIVE && n < FRAME_CYCLES) begin
			@(negedge vga_clk);
			n++;
			// vsync stays low for its lines, counted from the sample that saw it fall
			want_vs = (n < V_SYNC * H_TOTAL) ? 1'b0 : 1'b1;
			if (vsync_out !== want_vs) begin
				test_errors++;
				if (test_errors <= MAX_SHOWN)
					$display("error at %0t: vsync_out is %b, expected %b",
						$time, vsync_out, want_vs);
			end
			// pixels since the end of the active part of the line
			if (de)
				hpos = -1;
			else if (prev_de)
				hpos = 0;
			else if (hpos >= 0)
				hpos++;
			if (de || hpos >= 0) begin
				want_hs = (hpos >= H_FRONT && hpos < H_FRONT + H_SYNC) ? 1'b0 : 1'b1;
				if (hsync_out !== want_hs) begin
					test_errors++;
					if (test_errors <= MAX_SHOWN)
						$display("error at %0t: hsync_out is %b, expected %b on line %0d",
							$time, hsync_out, want_hs, y);
				end
			end
			if (de) begin
				want = expected_rgb(x, y, row);
				if ({red, green, blue} !== want) begin
					test_errors++;
					if (test_errors <= MAX_SHOWN)
						$display("error at %0t: pixel (%0d,%0d) is %h, expected %h",
							$time, x, y, {red, green, blue}, want);
				end
				x++;
			end else begin
				if ({red, green, blue} !== 12'h000) begin
					test_errors++;
					if (test_errors <= MAX_SHOWN)
						$display("error at %0t: color %h while de is low",
							$time, {red, green, blue});
				end
				if (prev_de) begin
					if (x != H_ACTIVE) begin
						test_errors++;
						$display("error at %0t: line %0d has %0d pixels", $time, y, x);
					end
					x = 0;
					y++;
				end
			end
			prev_de = de;
		end
		if (y < V_ACTIVE) begin
			$display("timeout: frame scan stopped at line %0d", y);
			timed_out = 1'b1;
		end
	endtask

	task automatic finish_test(string name);
		tests_run++;
		errors += test_errors;
		if (test_errors == 0 && !timed_out) begin
			$display("test %0d (%s): ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d (%s): failed, %0d errors", tests_run, name, test_errors);
		end
	endtask

	initial begin
		int seed_dummy;
		int r;
		rst_n          = 1'b0;
		health_req     = 1'b0;
		health_opp_in  = '0;
		health_user_in = '0;
		battle_state   = '0;
		bkg_index      = '0;
		sprite_index   = '0;
		errors         = 0;
		tests_run      = 0;
		tests_failed   = 0;
		timed_out      = 1'b0;
		seed_dummy     = $urandom(32'h7171);

		// state, opp, user, cursor corner, expected bar widths
		set_row(0, 4'd0, 8'd0, 8'd0, 0, 0, 0, 0);
		set_row(1, 4'd1, 8'd60, 8'd99, 292, 281, 20, 33);
		set_row(2, 4'd2, 8'd99, 8'd60, 352, 281, 33, 20);
		set_row(3, 4'd3, health_t'(100 + $urandom % 156), health_t'(100 + $urandom % 156),
			292, 303, 36, 38);
		set_row(4, 4'd4, 8'd0, 8'd60, 352, 303, 0, 20);
		set_row(5, 4'd7, 8'd60, 8'd0, 292, 303, 20, 0);

		repeat (10) @(negedge vga_clk);
		test_errors = 0;
		if (de !== 1'b0 || health_ack !== 1'b0 || {red, green, blue} !== 12'h000
				|| hsync_out !== 1'b1 || vsync_out !== 1'b1) begin
			$display("error at %0t: outputs not at their reset values", $time);
			test_errors++;
		end
		finish_test("reset values");
		rst_n = 1'b1;

		for (r = 0; r < NUM_ROWS && !timed_out; r++) begin
			test_errors  = 0;
			battle_state = row_state[r];
			load_health(row_opp[r], row_user[r]);
			if (!timed_out)
				wait_vsync_fall();
			if (!timed_out)
				scan_frame(r);
			finish_test($sformatf("state %0d, opp %0d, user %0d",
				row_state[r], row_opp[r], row_user[r]));
		end

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0 && !timed_out) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* build.f */
vga_timing_pkg.sv
battle_scene_pkg.sv
vga_raster_counter.sv
health_latch_fsm.sv
viewport_mapper.sv
hud_overlay.sv
pixel_compositor.sv
battle_display_top.sv
tb_battle_display.sv

/* Bender.yml */
package:
  name: battle_display

sources:
  - vga_timing_pkg.sv
  - battle_scene_pkg.sv
  - vga_raster_counter.sv
  - health_latch_fsm.sv
  - viewport_mapper.sv
  - hud_overlay.sv
  - pixel_compositor.sv
  - battle_display_top.sv
  - target: test
    files:
      - tb_battle_display.sv
